/* rtl/fpFormatPkg.sv */
`default_nettype none

package fpFormatPkg;

  localparam int ExpWidth  = 8;
  localparam int FracWidth = 23;            // Stored fraction, hidden bit not included

  localparam int ExpBias = 127;
  localparam int ExpMax  = 2 * ExpBias;     // Largest normal biased exponent

  typedef logic [ExpWidth-1:0]  expT;
  typedef logic [FracWidth-1:0] fracT;

  // Default single precision layout
  typedef struct packed {
    logic sign;
    expT  exp;
    fracT frac;
  } fpOperandT;

endpackage

`default_nettype wire

/* rtl/fpPipePkg.sv */
`default_nettype none

package fpPipePkg;

  import fpFormatPkg::*;

  localparam int SigWidth = FracWidth + 1;  // Fraction with hidden bit
  localparam int ExtWidth = SigWidth + 3;   // Plus guard, round and sticky

  typedef logic [SigWidth-1:0] sigT;
  typedef logic [ExtWidth-1:0] extT;

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } fpOpT;

  // Stage 1 to stage 2
  typedef struct packed {
    sigT        bigSig;
    sigT        smallSig;
    expT        exp;
    logic       sign;
    logic       effSub;
    logic [4:0] shiftAmt;
    logic       shiftOneMore;
    logic       toSticky;
  } alignReqT;

  // Stage 2 to stage 3
  typedef struct packed {
    extT  bigExt;
    extT  smallExt;
    expT  exp;
    logic sign;
    logic effSub;
  } alignedT;

  // Stage 3 to stage 4
  typedef struct packed {
    logic [SigWidth:0] raw;                 // Carry bit on top
    logic              guard;
    logic              round;
    logic              sticky;
    expT               exp;
    logic              sign;
  } sumT;

endpackage

`default_nettype wire

/* rtl/expCompare.sv */
`default_nettype none

module expCompare import fpFormatPkg::*, fpPipePkg::*; #(
  parameter int FracW = 23,
  parameter int ExpW  = 8
) (
  input  wire logic      clk,
  input  wire logic      rstN,
  input  wire logic      inReq,
  input  wire fpOpT      inOp,
  input  wire fpOperandT inA,
  input  wire fpOperandT inB,
  input  wire logic      ready,
  output logic           inAck,
  output logic           valid,
  output alignReqT       align
);

  localparam int SigW = FracW + 1;

  logic            accept;
  logic            aBigger;
  logic            signBEff;
  logic [SigW-1:0] sigA;
  logic [SigW-1:0] sigB;
  logic [ExpW-1:0] expDiff;
  logic [ExpW-1:0] diffM1;
  alignReqT        alignNext;

  assign accept = inReq && !inAck && !valid;

  assign sigA = (inA.exp == '0) ? '0 : {1'b1, inA.frac};   // Zero exponent flushes
  assign sigB = (inB.exp == '0) ? '0 : {1'b1, inB.frac};

  assign signBEff = inB.sign ^ (inOp == OP_SUB);
  assign aBigger  = {inA.exp, sigA} >= {inB.exp, sigB};

  assign expDiff = aBigger ? inA.exp - inB.exp : inB.exp - inA.exp;
  assign diffM1  = expDiff - 1'b1;

  always_comb begin
    alignNext.bigSig   = aBigger ? sigA : sigB;
    alignNext.smallSig = aBigger ? sigB : sigA;
    alignNext.exp      = aBigger ? inA.exp : inB.exp;
    alignNext.sign     = aBigger ? inA.sign : signBEff;
    alignNext.effSub   = inA.sign ^ signBEff;
    // Shifter takes one fixed extra step on any nonzero difference
    alignNext.shiftOneMore = (expDiff != '0);
    alignNext.shiftAmt     = alignNext.shiftOneMore ? diffM1[4:0] : 5'd0;
    alignNext.toSticky     = (expDiff >= FracW + 3);  // Past guard region
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      inAck <= 1'b0;
      valid <= 1'b0;
    end else begin
      if (accept) begin
        inAck <= 1'b1;
      end else if (!inReq) begin
        inAck <= 1'b0;                      // Return to zero phase
      end
      if (accept) begin
        valid <= 1'b1;
      end else if (ready) begin
        valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      align <= alignNext;
    end
  end

endmodule

`default_nettype wire

/* rtl/shiftRight.sv */
`default_nettype none

module shiftRight import fpPipePkg::*; #(
  parameter int FracW = 23
) (
  input  wire logic     clk,
  input  wire logic     rstN,
  input  wire logic     inValid,
  input  wire alignReqT align,
  input  wire logic     ready,
  output logic          inReady,
  output logic          valid,
  output alignedT       aligned
);

  localparam int VecW = FracW + 3;          // Significand, guard and round

  logic            load;
  logic            sticky;
  logic [VecW-1:0] vec;
  logic [VecW-1:0] mask;
  alignedT         alignedNext;

  assign inReady = !valid || ready;
  assign load    = inValid && inReady;

  always_comb begin
    vec    = {align.smallSig, 2'b00};
    sticky = 1'b0;
    mask   = '0;
    // Weighted levels 16, 8, 4, 2, 1
    for (int i = 4; i >= 0; i--) begin
      if (align.shiftAmt[i]) begin
        mask   = (VecW'(1) << (1 << i)) - 1'b1;
        sticky = sticky | (|(vec & mask));
        vec    = vec >> (1 << i);
      end
    end
    if (align.shiftOneMore) begin
      sticky = sticky | vec[0];
      vec    = vec >> 1;
    end
    if (align.toSticky) begin
      sticky = |align.smallSig;             // Whole operand collapses
      vec    = '0;
    end
    alignedNext.bigExt   = {align.bigSig, 3'b000};
    alignedNext.smallExt = {vec, sticky};
    alignedNext.exp      = align.exp;
    alignedNext.sign     = align.sign;
    alignedNext.effSub   = align.effSub;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid <= 1'b0;
    end else if (inReady) begin
      valid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      aligned <= alignedNext;
    end
  end

endmodule

`default_nettype wire

/* rtl/fracAdd.sv */
`default_nettype none

module fracAdd import fpPipePkg::*; #(
  parameter int FracW = 23
) (
  input  wire logic    clk,
  input  wire logic    rstN,
  input  wire logic    inValid,
  input  wire alignedT aligned,
  input  wire logic    ready,
  output logic         inReady,
  output logic         valid,
  output sumT          sum
);

  localparam int ExtW = FracW + 4;

  logic          load;
  logic [ExtW:0] bigOp;
  logic [ExtW:0] smallOp;
  logic [ExtW:0] total;
  sumT           sumNext;

  assign inReady = !valid || ready;
  assign load    = inValid && inReady;

  assign bigOp   = {1'b0, aligned.bigExt};
  assign smallOp = {1'b0, aligned.smallExt};

  // Operands are ordered, so the difference stays non-negative
  assign total = aligned.effSub ? bigOp - smallOp : bigOp + smallOp;

  always_comb begin
    sumNext.raw    = total[ExtW:3];
    sumNext.guard  = total[2];
    sumNext.round  = total[1];
    sumNext.sticky = total[0];
    sumNext.exp    = aligned.exp;
    sumNext.sign   = (total == '0) ? 1'b0 : aligned.sign;  // Exact zero is positive
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid <= 1'b0;
    end else if (inReady) begin
      valid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sum <= sumNext;
    end
  end

endmodule

`default_nettype wire

/* rtl/normRound.sv */
`default_nettype none

module normRound import fpFormatPkg::*, fpPipePkg::*; #(
  parameter int FracW = 23,
  parameter int ExpW  = 8
) (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic inValid,
  input  wire sumT  sum,
  input  wire logic outAck,
  output logic      inReady,
  output logic      outReq,
  output fpOperandT outResult,
  output logic      outOverflow
);

  localparam int SigW  = FracW + 1;
  localparam int NormW = SigW + 3;

  logic             load;
  logic             valid;
  logic [NormW-1:0] rawVec;
  logic [NormW-1:0] normVec;
  logic [ExpW:0]    lzCount;
  logic [ExpW:0]    shiftLimit;
  logic [ExpW:0]    normExp;
  logic [ExpW:0]    finalExp;
  logic             roundUp;
  logic [SigW:0]    rounded;
  logic             overflowNext;
  fpOperandT        resultNext;

  assign inReady = !valid || (!outReq && !outAck);
  assign load    = inValid && inReady;

  always_comb begin
    rawVec  = {sum.raw[SigW-1:0], sum.guard, sum.round, sum.sticky};
    lzCount = (ExpW + 1)'(NormW);
    for (int i = 0; i < NormW; i++) begin
      if (rawVec[i]) begin
        lzCount = (ExpW + 1)'(NormW - 1 - i);
      end
    end
    shiftLimit = (sum.exp == '0) ? '0 : {1'b0, sum.exp} - 1'b1;  // Down to exponent 1
    if (sum.raw[SigW]) begin
      normVec = {sum.raw[SigW:1], sum.raw[0], sum.guard, sum.round | sum.sticky};
      normExp = {1'b0, sum.exp} + 1'b1;
    end else if (lzCount <= shiftLimit) begin
      normVec = rawVec << lzCount;
      normExp = {1'b0, sum.exp} - lzCount;
    end else begin
      normVec = rawVec << shiftLimit;       // Hidden bit stays clear
      normExp = {1'b0, sum.exp} - shiftLimit;
    end

    roundUp  = normVec[2] && (normVec[1] || normVec[0] || normVec[3]);  // Nearest even
    rounded  = {1'b0, normVec[NormW-1:3]} + roundUp;
    finalExp = normExp + rounded[SigW];

    overflowNext    = 1'b0;
    resultNext.sign = sum.sign;
    if (!normVec[NormW-1]) begin
      resultNext.exp  = '0;                 // Flush to zero
      resultNext.frac = '0;
    end else if (finalExp > ExpMax) begin
      resultNext.exp  = expT'(ExpMax);
      resultNext.frac = '1;
      overflowNext    = 1'b1;
    end else begin
      resultNext.exp  = finalExp[ExpW-1:0];
      resultNext.frac = rounded[FracW-1:0];  // Zero after a rounding carry
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid       <= 1'b0;
      outReq      <= 1'b0;
      outOverflow <= 1'b0;
    end else if (load) begin
      valid       <= 1'b1;
      outReq      <= 1'b1;
      outOverflow <= overflowNext;
    end else begin
      if (outReq && outAck) begin
        outReq <= 1'b0;
      end
      if (!outReq && !outAck) begin
        valid <= 1'b0;                      // Four-phase cycle complete
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      outResult <= resultNext;
    end
  end

endmodule

`default_nettype wire

/* rtl/fpAddTop.sv */
`default_nettype none

module fpAddTop import fpFormatPkg::*, fpPipePkg::*; #(
  parameter int FracW = 23,
  parameter int ExpW  = 8
) (
  input  wire logic      clk,
  input  wire logic      rstN,
  input  wire logic      inReq,
  input  wire fpOpT      inOp,
  input  wire fpOperandT inA,
  input  wire fpOperandT inB,
  input  wire logic      outAck,
  output logic           inAck,
  output logic           outReq,
  output fpOperandT      outResult,
  output logic           outOverflow
);

  logic     alignValid;
  logic     alignReady;
  logic     alignedValid;
  logic     alignedReady;
  logic     sumValid;
  logic     sumReady;
  alignReqT align;
  alignedT  aligned;
  sumT      sum;

  expCompare #(
    .FracW(FracW),
    .ExpW (ExpW)
  ) u_expCompare (
    .clk  (clk),
    .rstN (rstN),
    .inReq(inReq),
    .inOp (inOp),
    .inA  (inA),
    .inB  (inB),
    .ready(alignReady),
    .inAck(inAck),
    .valid(alignValid),
    .align(align)
  );

  shiftRight #(
    .FracW(FracW)
  ) u_shiftRight (
    .clk    (clk),
    .rstN   (rstN),
    .inValid(alignValid),
    .align  (align),
    .ready  (alignedReady),
    .inReady(alignReady),
    .valid  (alignedValid),
    .aligned(aligned)
  );

  fracAdd #(
    .FracW(FracW)
  ) u_fracAdd (
    .clk    (clk),
    .rstN   (rstN),
    .inValid(alignedValid),
    .aligned(aligned),
    .ready  (sumReady),
    .inReady(alignedReady),
    .valid  (sumValid),
    .sum    (sum)
  );

  normRound #(
    .FracW(FracW),
    .ExpW (ExpW)
  ) u_normRound (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (sumValid),
    .sum        (sum),
    .outAck     (outAck),
    .inReady    (sumReady),
    .outReq     (outReq),
    .outResult  (outResult),
    .outOverflow(outOverflow)
  );

endmodule

`default_nettype wire

/* verification/fpAdd_chk.sv */
`default_nettype none

module fpAdd_chk import fpFormatPkg::*; (
  input wire logic      clk,
  input wire logic      rstN,
  input wire logic      inReq,
  input wire logic      inAck,
  input wire logic      outReq,
  input wire logic      outAck,
  input wire fpOperandT outResult
);

  int assertFails = 0;

  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    $rose(inAck) |-> $past(inReq))
  else begin
    $error("inAck rose while inReq was low");
    assertFails++;
  end

  resultHeld: assert property (@(posedge clk) disable iff (!rstN)
    outReq && $past(outReq) |-> $stable(outResult))
  else begin
    $error("outResult changed while outReq was high");
    assertFails++;
  end

  // Request drops only once the far side answered
  reqDropAfterAck: assert property (@(posedge clk) disable iff (!rstN)
    $fell(outReq) |-> $past(outAck))
  else begin
    $error("outReq fell without outAck");
    assertFails++;
  end

  quietInReset: assert property (@(posedge clk) !rstN |-> !outReq)
  else begin
    $error("outReq high during reset");
    assertFails++;
  end

endmodule

bind fpAddTop fpAdd_chk u_fpAddChk (
  .clk      (clk),
  .rstN     (rstN),
  .inReq    (inReq),
  .inAck    (inAck),
  .outReq   (outReq),
  .outAck   (outAck),
  .outResult(outResult)
);

`default_nettype wire

/* verification/fpAddTb.sv */
`default_nettype none

module fpAddTb
  import fpFormatPkg::*, fpPipePkg::*;
();

  localparam int MaxVec  = 64;
  localparam int Latency = 3;               // inAck rise to outReq rise

  logic      clk = 1'b0;
  logic      rstN;
  logic      inReq;
  fpOpT      inOp;
  fpOperandT inA;
  fpOperandT inB;
  logic      outAck;
  logic      inAck;
  logic      outReq;
  fpOperandT outResult;
  logic      outOverflow;

  logic [8*16-1:0] vecName [MaxVec];
  logic            vecOp [MaxVec];
  logic [31:0]     vecA [MaxVec];
  logic [31:0]     vecB [MaxVec];
  logic [31:0]     vecRes [MaxVec];
  logic            vecOvf [MaxVec];
  int              ackCycle [2*MaxVec];

  int         numVec = 0;
  int         cycle = 0;
  int         passCount = 0;
  int         failCount = 0;
  int         doneCount = 0;
  logic       started = 1'b0;
  logic [7:0] lfsr = 8'd37;

  fpAddTop #(
    .FracW(23),
    .ExpW (8)
  ) u_fpAddTop (
    .clk        (clk),
    .rstN       (rstN),
    .inReq      (inReq),
    .inOp       (inOp),
    .inA        (inA),
    .inB        (inB),
    .outAck     (outAck),
    .inAck      (inAck),
    .outReq     (outReq),
    .outResult  (outResult),
    .outOverflow(outOverflow)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Galois form, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] stepLfsr(input logic [7:0] state);
    logic [7:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 8'hB8;
    end
    return next;
  endfunction

  task automatic loadVectors();
    int               fd;
    int               code;
    logic [8*128-1:0] lineBuf;
    logic [8*16-1:0]  name;
    logic [31:0]      op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      res;
    logic [31:0]      ovf;
    fd = $fopen("verification/fpAddInput.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/fpAddInput.txt");
    end else begin
      while ($fgets(lineBuf, fd) != 0) begin
        code = $sscanf(lineBuf, "%s %h %h %h %h %h", name, op, a, b, res, ovf);
        if (code == 6 && numVec < MaxVec) begin  // Comment lines do not parse
          vecName[numVec] = name;
          vecOp[numVec]   = op[0];
          vecA[numVec]    = a;
          vecB[numVec]    = b;
          vecRes[numVec]  = res;
          vecOvf[numVec]  = ovf[0];
          numVec++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin : setup
    rstN   = 1'b0;
    inReq  = 1'b0;
    inOp   = OP_ADD;
    inA    = '0;
    inB    = '0;
    outAck = 1'b0;
    loadVectors();
    if (numVec == 0) begin
      $display("No test vectors were loaded");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      repeat (4) @(posedge clk);
      @(negedge clk);
      rstN    = 1'b1;
      started = 1'b1;
    end
  end

  // Second run repeats all vectors with a stalled outAck
  initial begin : driver
    wait (started);
    for (int run = 0; run < 2; run++) begin
      for (int i = 0; i < numVec; i++) begin
        @(negedge clk);
        inOp  = vecOp[i] ? OP_SUB : OP_ADD;
        inA   = vecA[i];
        inB   = vecB[i];
        inReq = 1'b1;
        do begin
          @(negedge clk);
        end while (!inAck);
        ackCycle[run * numVec + i] = cycle;
        inReq = 1'b0;
        do begin
          @(negedge clk);
        end while (inAck);
      end
    end
  end

  initial begin : monitor
    int         idx;
    logic       bad;
    logic [1:0] stall;
    wait (started);
    for (int k = 0; k < 2 * numVec; k++) begin
      idx = k % numVec;
      do begin
        @(negedge clk);
      end while (!outReq);
      bad = 1'b0;
      if (k < numVec && cycle - ackCycle[k] != Latency) begin
        $display("ERR %0s latency expected %0d actual %0d",
                 vecName[idx], Latency, cycle - ackCycle[k]);
        bad = 1'b1;
      end
      if (outResult !== vecRes[idx] || outOverflow !== vecOvf[idx]) begin
        $display("ERR %0s expected %h ovf %b actual %h ovf %b",
                 vecName[idx], vecRes[idx], vecOvf[idx], outResult, outOverflow);
        bad = 1'b1;
      end
      if (bad) begin
        failCount++;
      end else begin
        passCount++;
      end
      $display("test %0s run %0d %s", vecName[idx], k / numVec, bad ? "failed" : "ok");
      stall = '0;
      if (k >= numVec) begin
        for (int b = 0; b < 2; b++) begin
          stall = {stall[0], lfsr[0]};
          lfsr  = stepLfsr(lfsr);
        end
      end
      repeat (stall) @(negedge clk);
      outAck = 1'b1;
      do begin
        @(negedge clk);
      end while (outReq);
      outAck = 1'b0;
      doneCount++;
    end
    $display("Tests passed %0d, failed %0d, assertion failures %0d",
             passCount, failCount, u_fpAddTop.u_fpAddChk.assertFails);
    if (failCount == 0 && u_fpAddTop.u_fpAddChk.assertFails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    wait (started);
    repeat (numVec * 40) @(posedge clk);
    $display("Run timed out with %0d of %0d results received", doneCount, 2 * numVec);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/fpFormatPkg.sv
rtl/fpPipePkg.sv
rtl/expCompare.sv
rtl/shiftRight.sv
rtl/fracAdd.sv
rtl/normRound.sv
rtl/fpAddTop.sv
verification/fpAdd_chk.sv
verification/fpAddTb.sv

/* Bender.yml */
package:
  name: fpAdd

sources:
  - files:
      - rtl/fpFormatPkg.sv
      - rtl/fpPipePkg.sv
      - rtl/expCompare.sv
      - rtl/shiftRight.sv
      - rtl/fracAdd.sv
      - rtl/normRound.sv
      - rtl/fpAddTop.sv
  - target: simulation
    files:
      - verification/fpAdd_chk.sv
      - verification/fpAddTb.sv

/* verification/fpAddInput.txt */
# Test name, opcode (0 add, 1 sub), operand A, operand B, expected result, expected overflow
# Values in hex, single precision layout
add_equal     0 3F800000 3F800000 40000000 0
add_diff1     0 3FC00000 3F400000 40100000 0
add_swap      0 3F800000 40000000 40400000 0
shift_d9      0 3F800000 3B000000 3F804000 0
shift_d17     0 3F800000 37000000 3F800040 0
shift_d24_rnd 0 3F800000 33C00000 3F800001 0
shift_d24_stk 0 3F800000 33800001 3F800001 0
shift_sticky  0 3F800000 30800000 3F800000 0
sub_exact     1 3FC00000 3FC00000 00000000 0
add_cancel    0 BFC00000 3FC00000 00000000 0
sub_ulp       1 3F800000 3F7FFFFF 33800000 0
sub_norm      1 3FC00000 3FA00000 3E800000 0
sub_neg       1 3F800000 40400000 C0000000 0
tie_even      0 3F800000 33800000 3F800000 0
tie_odd       0 3F800001 33800000 3F800002 0
rnd_carry     0 3FFFFFFF 33800000 40000000 0
carry_rnd     0 3F800003 3F800000 40000002 0
ovf_pos       0 7F7FFFFF 7F7FFFFF 7F7FFFFF 1
ovf_neg       0 FF000000 FF000000 FF7FFFFF 1
zero_denorm   0 00400000 3F800000 3F800000 0
tiny_flush    1 00800001 00800000 00000000 0
